/* Makefile */
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only if the pass message appears in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* bench/rvCoreTb.sv */
`default_nettype none
`include "rv_consts.svh"

module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int progLen       = 29;
    localparam int numStores     = 6;
    localparam int timeoutCycles = 500;
    localparam int drainCycles   = 20;
    localparam logic [31:0] sentinelAddr = 32'h0000_00FC;  // Wrong-path stores aim here
    localparam logic [31:0] loadAddr     = 32'h0000_0020;  // The only LW reads word 8
    localparam logic [31:0] fillBase     = 32'h1357_0000;
    localparam logic [31:0] fillStep     = 32'h0000_0111;

    localparam logic [31:0] progWords [0:progLen-1] = '{
        32'h01D00093, 32'h03608113, 32'h002081B3, 32'h40118233,  // addi, addi, add, sub
        32'h003272B3, 32'h0012E333, 32'h004343B3, 32'h0013A433,  // and, or, xor, slt
        32'hFFD00493, 32'h0084A533,                              // addi x9,-3 ; slt x10,x9,x8
        32'h00A02823, 32'h00702223, 32'h00502423,                // sw x10,16 ; sw x7,4 ; sw x5,8
        32'h02002583, 32'h00158633, 32'h00C02A23,                // lw x11,32 ; add x12 ; sw x12,20
        32'h00410663, 32'h0E102E23, 32'h0E102E23,                // beq x2,x4,+12 ; wrong path
        32'h00209663, 32'h0E202E23, 32'h0E202E23,                // bne x1,x2,+12 ; wrong path
        32'h00411663, 32'h00402C23,                              // bne x2,x4 falls ; sw x4,24
        32'h00C006EF, 32'h0E102E23, 32'h0E102E23,                // jal x13,+12 ; wrong path
        32'h00D02E23, 32'h0000006F                               // sw x13,28 ; jal x0,0
    };

    // Register values of the program under RV32I rules
    localparam logic [31:0] x1Val  = 32'd29;
    localparam logic [31:0] x2Val  = x1Val + 32'd54;
    localparam logic [31:0] x3Val  = x1Val + x2Val;
    localparam logic [31:0] x4Val  = x3Val - x1Val;
    localparam logic [31:0] x5Val  = x4Val & x3Val;
    localparam logic [31:0] x6Val  = x5Val | x1Val;
    localparam logic [31:0] x7Val  = x6Val ^ x4Val;
    localparam logic [31:0] x8Val  = ($signed(x7Val) < $signed(x1Val)) ? 32'd1 : 32'd0;
    localparam logic [31:0] x9Val  = 32'hFFFF_FFFD;                     // -3
    localparam logic [31:0] x10Val = ($signed(x9Val) < $signed(x8Val)) ? 32'd1 : 32'd0;
    localparam logic [31:0] x12Val = fillBase + 32'd8 * fillStep + x1Val;  // Data word 8 plus x1
    localparam logic [31:0] linkVal = 32'd24 * 32'd4 + 32'd4;           // JAL sits at word 24

    // Expected stores in program order with the instructions executed before each
    localparam logic [31:0] expAddr [0:numStores-1] = '{
        32'd16, 32'd4, 32'd8, 32'd20, 32'd24, 32'd28
    };
    localparam logic [31:0] expData [0:numStores-1] = '{
        x10Val, x7Val, x5Val, x12Val, x4Val, linkVal
    };
    localparam logic [`CNT_W-1:0] expIndex [0:numStores-1] = '{
        64'd10, 64'd11, 64'd12, 64'd15, 64'd19, 64'd21
    };

    logic iCLK;
    logic iRST;
    logic [`XLEN-1:0] instrAddr, instrData, dataAddr, dataWriteData, dataReadData;
    logic dataWriteEnable, dataReadEnable;
    logic [`CNT_W-1:0] retired;

    logic [31:0] imem [0:31];
    logic [31:0] dmem [0:63];
    int errors = 0;
    int storeCount = 0;
    int loadCount = 0;
    string testName [0:numStores-1] = '{
        "slt signed", "xor chain", "and forward", "load-use", "bne not taken", "jal link"
    };

    rvCore rvCore_i (
        .iCLK(iCLK), .iRST(iRST),
        .instrAddr(instrAddr), .instrData(instrData),
        .dataAddr(dataAddr), .dataWriteData(dataWriteData), .dataReadData(dataReadData),
        .dataWriteEnable(dataWriteEnable), .dataReadEnable(dataReadEnable),
        .retired(retired)
    );

    function automatic logic [31:0] fillWord(input int idx);
        return fillBase + idx * fillStep;
    endfunction

    // ******************************************************************
    // Memory models
    assign instrData    = imem[instrAddr[6:2]];
    assign dataReadData = dmem[dataAddr[7:2]];

    always @(posedge iCLK) begin
        if (dataWriteEnable)
            dmem[dataAddr[7:2]] <= dataWriteData;
    end

    // ******************************************************************
    // Store checks sampled mid-cycle
    task automatic checkStore();
        int k;
        k = storeCount;
        if (dataAddr == sentinelAddr) begin
            $display("wrong-path store reached the sentinel address at %0t", $time);
            errors++;
        end else if (k >= numStores) begin
            $display("unexpected extra store to address %h at %0t", dataAddr, $time);
            errors++;
            storeCount++;
        end else begin
            assert (dataAddr == expAddr[k]) else begin
                $display("mismatch %s address: expected %h, actual %h",
                         testName[k], expAddr[k], dataAddr);
                errors++;
            end
            assert (dataWriteData == expData[k]) else begin
                $display("mismatch %s data: expected %h, actual %h",
                         testName[k], expData[k], dataWriteData);
                errors++;
            end
            assert (retired == expIndex[k] || retired == expIndex[k] - `CNT_W'd1) else begin
                $display("mismatch %s retired: expected %0d or %0d, actual %0d",
                         testName[k], expIndex[k], expIndex[k] - `CNT_W'd1, retired);
                errors++;
            end
            storeCount++;
        end
    endtask

    always @(negedge iCLK) begin
        if (!iRST && dataWriteEnable)
            checkStore();
    end

    // The program reads data with its one LW only
    always @(negedge iCLK) begin
        if (!iRST && dataReadEnable) begin
            assert (dataAddr == loadAddr) else begin
                $display("mismatch load address: expected %h, actual %h",
                         loadAddr, dataAddr);
                errors++;
            end
            loadCount++;
        end
    end

    initial begin
        iCLK = 1'b0;
        forever #10 iCLK = ~iCLK;
    end

    // ******************************************************************
    // Main sequence
    initial begin
        int cycles;
        iRST = 1'b1;
        for (int i = 0; i < 32; i++)
            imem[i] = (i < progLen) ? progWords[i] : `NOP_WORD;
        for (int i = 0; i < 64; i++)
            dmem[i] = fillWord(i);
        repeat (4) @(posedge iCLK);
        #1 iRST = 1'b0;

        cycles = 0;
        while (storeCount < numStores && cycles < timeoutCycles) begin
            @(posedge iCLK);
            cycles++;
        end
        if (storeCount < numStores) begin
            $display("timeout: only %0d of %0d stores seen within %0d cycles",
                     storeCount, numStores, timeoutCycles);
            errors++;
        end

        cycles = 0;
        while (cycles < drainCycles) begin      // A late wrong-path store still shows up
            @(posedge iCLK);
            cycles++;
        end

        assert (loadCount == 1) else begin
            $display("mismatch load count: expected 1, actual %0d", loadCount);
            errors++;
        end

        $display("closing report: %0d errors, %0d of %0d stores checked",
                 errors, storeCount, numStores);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rvCore_asserts.sv */
`default_nettype none
`include "rv_consts.svh"

module rvCoreAsserts (
    input  wire                 iCLK,
    input  wire                 iRST,
    input  wire  [`XLEN-1:0]    instrAddr,
    input  wire                 dataWriteEnable,
    input  wire                 dataReadEnable,
    input  wire  [`CNT_W-1:0]   retired
);
    timeunit 1ns;
    timeprecision 1ps;

    // ******************************************************************
    // Reset state
    resetClear: assert property (@(posedge iCLK)
        iRST |-> (!dataWriteEnable && !dataReadEnable && retired == '0))
        else $error("bus enables or retire count not cleared during reset");

    // First edge out of reset still sees the reset PC
    firstFetch: assert property (@(posedge iCLK)
        $fell(iRST) |-> instrAddr == `RESET_PC)
        else $error("first fetch after reset is not at the reset PC");

    // ******************************************************************
    // Running state
    oneAccess: assert property (@(posedge iCLK) disable iff (iRST)
        !(dataWriteEnable && dataReadEnable))
        else $error("data read and write enables high together");

    wordAligned: assert property (@(posedge iCLK) disable iff (iRST)
        instrAddr[1:0] == 2'b00)
        else $error("instruction address %h not word aligned", instrAddr);

    // At most one retirement per cycle
    countStep: assert property (@(posedge iCLK) disable iff (iRST)
        retired == $past(retired) || retired == $past(retired) + `CNT_W'd1)
        else $error("retire count rose by more than one, now %0d", retired);

endmodule

bind rvCore rvCoreAsserts asserts_i (
    .iCLK(iCLK),
    .iRST(iRST),
    .instrAddr(instrAddr),
    .dataWriteEnable(dataWriteEnable),
    .dataReadEnable(dataReadEnable),
    .retired(retired)
);

`default_nettype wire

/* common/rvPkg.sv */
`default_nettype none

package rvPkg;

    // Register and funct fields of the R and I formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields;

    // Split immediate of the S and B formats
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFields;

    typedef union packed {
        rFields rView;
        sFields sView;
    } instrWord;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } aluOp;

    // Operand source for the EX stage
    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwdSel;

    typedef enum logic [1:0] {
        WB_ALU, WB_LOAD, WB_LINK
    } wbSel;

endpackage

`default_nettype wire

/* common/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define CNT_W       64

`define RESET_PC    32'h0000_0000

// Major opcodes of the kept RV32I subset
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

`define NOP_WORD    32'h0000_0013  // addi x0,x0,0

`endif

/* decode/decodeStage.sv */
`default_nettype none
`include "rv_consts.svh"

module decodeStage (
    input  wire                     iCLK,
    input  wire                     iRST,
    input  wire                     stall,
    input  wire                     flush,
    input  wire  [`XLEN-1:0]        idPc,
    input  rvPkg::instrWord         idInstr,
    input  wire  [`REG_ADDR_W-1:0]  wbRd,
    input  wire  [`XLEN-1:0]        wbData,
    input  wire                     wbWrite,
    output logic [`XLEN-1:0]        exPc,
    output logic [`XLEN-1:0]        exRs1Val,
    output logic [`XLEN-1:0]        exRs2Val,
    output logic [`XLEN-1:0]        exImm,
    output rvPkg::aluOp             exAluOp,
    output logic                    exUseImm,
    output logic [`REG_ADDR_W-1:0]  exRs1,
    output logic [`REG_ADDR_W-1:0]  exRs2,
    output logic [`REG_ADDR_W-1:0]  exRd,
    output logic                    exMemRead,
    output logic                    exMemWrite,
    output logic                    exRegWrite,
    output logic                    exBranch,
    output logic                    exBranchNe,
    output logic                    exJump,
    output rvPkg::wbSel             exWbSel,
    output logic                    exValid
);
    import rvPkg::*;

    logic [`XLEN-1:0] rs1Val, rs2Val;
    logic [`XLEN-1:0] immI, immS, immB, immJ, imm;
    aluOp aluSel;
    wbSel wbChoice;
    logic useImm, memRead, memWrite, regWrite, branch, jump, valid;
    logic bubble;

    // Integer ops share one funct3 map and only OP has SUB
    function automatic aluOp funct3Op(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    regFile regFile_i (
        .iCLK(iCLK), .iRST(iRST),
        .rs1(idInstr.rView.rs1), .rs2(idInstr.rView.rs2), .rd(wbRd),
        .writeData(wbData), .writeEnable(wbWrite),
        .rs1Val(rs1Val), .rs2Val(rs2Val)
    );

    // *********************************************************************
    // Immediates
    assign immI = {{20{idInstr.rView.funct7[6]}}, idInstr.rView.funct7, idInstr.rView.rs2};
    assign immS = {{20{idInstr.sView.immHi[6]}}, idInstr.sView.immHi, idInstr.sView.immLo};
    assign immB = {{19{idInstr.sView.immHi[6]}}, idInstr.sView.immHi[6],
                   idInstr.sView.immLo[0], idInstr.sView.immHi[5:0],
                   idInstr.sView.immLo[4:1], 1'b0};
    assign immJ = {{12{idInstr.rView.funct7[6]}}, idInstr.rView.rs1, idInstr.rView.funct3,
                   idInstr.rView.rs2[0], idInstr.rView.funct7[5:0],
                   idInstr.rView.rs2[4:1], 1'b0};

    // *********************************************************************
    // Control decode
    always_comb begin
        aluSel   = ALU_ADD;
        wbChoice = WB_ALU;
        imm      = immI;
        useImm   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        valid    = 1'b1;
        case (idInstr.rView.opcode)
            `OPC_OP: begin
                regWrite = 1'b1;
                aluSel   = funct3Op(idInstr.rView.funct3, idInstr.rView.funct7[5]);
            end
            `OPC_OPIMM: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                aluSel   = funct3Op(idInstr.rView.funct3, 1'b0);
            end
            `OPC_LOAD: begin
                memRead  = 1'b1;
                regWrite = 1'b1;
                useImm   = 1'b1;
                wbChoice = WB_LOAD;
            end
            `OPC_STORE: begin
                memWrite = 1'b1;
                useImm   = 1'b1;
                imm      = immS;
            end
            `OPC_BRANCH: begin
                branch = 1'b1;
                imm    = immB;
            end
            `OPC_JAL: begin
                jump     = 1'b1;
                regWrite = 1'b1;
                imm      = immJ;
                wbChoice = WB_LINK;
            end
            default: valid = 1'b0;      // Unknown opcode retires nothing
        endcase
        if (idInstr == `NOP_WORD)
            valid = 1'b0;               // Squashed slot is not counted
    end

    // *********************************************************************
    // ID/EX register
    assign bubble = stall || flush;     // Slot leaves ID as a bubble

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
            exBranch   <= 1'b0;
            exJump     <= 1'b0;
            exValid    <= 1'b0;
        end else begin
            exMemRead  <= memRead && !bubble;
            exMemWrite <= memWrite && !bubble;
            exRegWrite <= regWrite && !bubble;
            exBranch   <= branch && !bubble;
            exJump     <= jump && !bubble;
            exValid    <= valid && !bubble;
        end
    end

    always_ff @(posedge iCLK) begin
        exPc       <= idPc;
        exRs1Val   <= rs1Val;
        exRs2Val   <= rs2Val;
        exImm      <= imm;
        exAluOp    <= aluSel;
        exUseImm   <= useImm;
        exWbSel    <= wbChoice;
        exBranchNe <= idInstr.rView.funct3[0];  // BNE differs from BEQ in bit 0
        exRs1      <= idInstr.rView.rs1;
        exRs2      <= idInstr.rView.rs2;
        exRd       <= idInstr.rView.rd;
    end

endmodule

`default_nettype wire

/* decode/regFile.sv */
`default_nettype none
`include "rv_consts.svh"

module regFile (
    input  wire                     iCLK,
    input  wire                     iRST,
    input  wire  [`REG_ADDR_W-1:0]  rs1,
    input  wire  [`REG_ADDR_W-1:0]  rs2,
    input  wire  [`REG_ADDR_W-1:0]  rd,
    input  wire  [`XLEN-1:0]        writeData,
    input  wire                     writeEnable,
    output logic [`XLEN-1:0]        rs1Val,
    output logic [`XLEN-1:0]        rs2Val
);
    logic [`XLEN-1:0] regs [1:31];   // x0 is not stored

    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (writeEnable && idx == rd)
            return writeData;           // Same-cycle WB bypass
        return regs[idx];
    endfunction

    always_comb rs1Val = readPort(rs1);
    always_comb rs2Val = readPort(rs2);

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (writeEnable && rd != '0) begin
            regs[rd] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`default_nettype none
`include "rv_consts.svh"

module fetchStage (
    input  wire                 iCLK,
    input  wire                 iRST,
    input  wire                 stall,
    input  wire                 flush,
    input  wire                 branchTaken,
    input  wire  [`XLEN-1:0]    branchTarget,
    input  wire  [`XLEN-1:0]    instrData,
    output logic [`XLEN-1:0]    instrAddr,
    output logic [`XLEN-1:0]    idPc,
    output rvPkg::instrWord     idInstr
);
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;

    assign instrAddr = pc;

    // Redirect wins over a load-use hold
    always_comb begin
        if (branchTaken)
            nextPc = branchTarget;
        else if (stall)
            nextPc = pc;
        else
            nextPc = pc + `XLEN'd4;
    end

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            pc      <= `RESET_PC;
            idInstr <= `NOP_WORD;
        end else begin
            pc <= nextPc;
            if (flush)
                idInstr <= `NOP_WORD;   // Wrong-path fetch squashed
            else if (!stall)
                idInstr <= instrData;
        end
    end

    always_ff @(posedge iCLK) begin
        if (!stall)
            idPc <= pc;
    end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`default_nettype none
`include "rv_consts.svh"

module hazardUnit (
    input  wire  [`REG_ADDR_W-1:0]  exRs1,
    input  wire  [`REG_ADDR_W-1:0]  exRs2,
    input  wire  [`REG_ADDR_W-1:0]  memRd,
    input  wire                     memRegWrite,
    input  wire  [`REG_ADDR_W-1:0]  wbRd,
    input  wire                     wbWrite,
    input  wire  [`REG_ADDR_W-1:0]  idRs1,
    input  wire  [`REG_ADDR_W-1:0]  idRs2,
    input  wire  [`REG_ADDR_W-1:0]  exRd,
    input  wire                     exMemRead,
    input  wire                     branchTaken,
    output logic                    stall,
    output logic                    flush,
    output rvPkg::fwdSel            fwdA,
    output rvPkg::fwdSel            fwdB
);
    import rvPkg::*;

    logic loadUse;

    // Youngest producer wins
    function automatic fwdSel sourceFor(input logic [`REG_ADDR_W-1:0] rs);
        if (memRegWrite && memRd != '0 && memRd == rs)
            return FWD_MEM;
        if (wbWrite && wbRd != '0 && wbRd == rs)
            return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb fwdA = sourceFor(exRs1);
    always_comb fwdB = sourceFor(exRs2);

    // Load result arrives one cycle too late for the next instruction
    assign loadUse = exMemRead && exRd != '0 && (exRd == idRs1 || exRd == idRs2);

    assign flush = branchTaken;
    assign stall = loadUse && !branchTaken;     // Flush has priority

endmodule

`default_nettype wire

/* design/memWbStage.sv */
`default_nettype none
`include "rv_consts.svh"

module memWbStage (
    input  wire                     iCLK,
    input  wire                     iRST,
    input  wire  [`XLEN-1:0]        memAluResult,
    input  wire  [`REG_ADDR_W-1:0]  memRd,
    input  wire                     memRegWrite,
    input  rvPkg::wbSel             memWbSel,
    input  wire  [`XLEN-1:0]        memLink,
    input  wire                     memValid,
    input  wire  [`XLEN-1:0]        dataReadData,
    output logic [`REG_ADDR_W-1:0]  wbRd,
    output logic [`XLEN-1:0]        wbData,
    output logic                    wbWrite,
    output logic                    retirePulse
);
    import rvPkg::*;

    logic [`XLEN-1:0] wbAlu, wbLoad, wbLink;
    wbSel wbChoice;

    // MEM/WB register
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            wbWrite     <= 1'b0;
            retirePulse <= 1'b0;
        end else begin
            wbWrite     <= memRegWrite;
            retirePulse <= memValid;    // One pulse per real instruction
        end
    end

    always_ff @(posedge iCLK) begin
        wbAlu    <= memAluResult;
        wbLoad   <= dataReadData;
        wbLink   <= memLink;
        wbRd     <= memRd;
        wbChoice <= memWbSel;
    end

    always_comb begin
        case (wbChoice)
            WB_LOAD: wbData = wbLoad;
            WB_LINK: wbData = wbLink;
            default: wbData = wbAlu;
        endcase
    end

endmodule

`default_nettype wire

/* design/retireCounter.sv */
`default_nettype none
`include "rv_consts.svh"

module retireCounter (
    input  wire                 iCLK,
    input  wire                 iRST,
    input  wire                 retirePulse,
    output logic [`CNT_W-1:0]   retired
);
    // Count visible one cycle after the pulse
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST)
            retired <= '0;
        else if (retirePulse)
            retired <= retired + `CNT_W'd1;
    end

endmodule

`default_nettype wire

/* design/rvCore.sv */
`default_nettype none
`include "rv_consts.svh"

module rvCore (
    input  wire                 iCLK,
    input  wire                 iRST,
    output logic [`XLEN-1:0]    instrAddr,
    input  wire  [`XLEN-1:0]    instrData,
    output logic [`XLEN-1:0]    dataAddr,
    output logic [`XLEN-1:0]    dataWriteData,
    input  wire  [`XLEN-1:0]    dataReadData,
    output logic                dataWriteEnable,
    output logic                dataReadEnable,
    output logic [`CNT_W-1:0]   retired
);
    import rvPkg::*;

    // IF/ID
    logic [`XLEN-1:0] idPc;
    instrWord idInstr;

    // Hazard control
    logic stall, flush;
    fwdSel fwdA, fwdB;
    logic branchTaken;
    logic [`XLEN-1:0] branchTarget;

    // ID/EX
    logic [`XLEN-1:0] exPc, exRs1Val, exRs2Val, exImm;
    aluOp exAluOp;
    wbSel exWbSel;
    logic [`REG_ADDR_W-1:0] exRs1, exRs2, exRd;
    logic exUseImm, exMemRead, exMemWrite, exRegWrite;
    logic exBranch, exBranchNe, exJump, exValid;

    // EX/MEM
    logic [`REG_ADDR_W-1:0] memRd;
    logic [`XLEN-1:0] memLink;
    wbSel memWbSel;
    logic memRegWrite, memValid;

    // Writeback
    logic [`REG_ADDR_W-1:0] wbRd;
    logic [`XLEN-1:0] wbData;
    logic wbWrite, retirePulse;

    fetchStage fetch_i (
        .iCLK(iCLK), .iRST(iRST),
        .stall(stall), .flush(flush),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instrData(instrData), .instrAddr(instrAddr),
        .idPc(idPc), .idInstr(idInstr)
    );

    decodeStage decode_i (
        .iCLK(iCLK), .iRST(iRST),
        .stall(stall), .flush(flush),
        .idPc(idPc), .idInstr(idInstr),
        .wbRd(wbRd), .wbData(wbData), .wbWrite(wbWrite),
        .exPc(exPc), .exRs1Val(exRs1Val), .exRs2Val(exRs2Val), .exImm(exImm),
        .exAluOp(exAluOp), .exUseImm(exUseImm),
        .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd),
        .exMemRead(exMemRead), .exMemWrite(exMemWrite), .exRegWrite(exRegWrite),
        .exBranch(exBranch), .exBranchNe(exBranchNe), .exJump(exJump),
        .exWbSel(exWbSel), .exValid(exValid)
    );

    executeStage execute_i (
        .iCLK(iCLK), .iRST(iRST),
        .exPc(exPc), .exRs1Val(exRs1Val), .exRs2Val(exRs2Val), .exImm(exImm),
        .exAluOp(exAluOp), .exUseImm(exUseImm), .exRd(exRd),
        .exMemRead(exMemRead), .exMemWrite(exMemWrite), .exRegWrite(exRegWrite),
        .exBranch(exBranch), .exBranchNe(exBranchNe), .exJump(exJump),
        .exWbSel(exWbSel), .exValid(exValid),
        .fwdA(fwdA), .fwdB(fwdB),
        .memAluResult(dataAddr), .wbData(wbData),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .memAddr(dataAddr), .memStoreData(dataWriteData), .memRd(memRd),
        .memRegWrite(memRegWrite), .memRead(dataReadEnable), .memWrite(dataWriteEnable),
        .memWbSel(memWbSel), .memLink(memLink), .memValid(memValid)
    );

    memWbStage memWb_i (
        .iCLK(iCLK), .iRST(iRST),
        .memAluResult(dataAddr), .memRd(memRd), .memRegWrite(memRegWrite),
        .memWbSel(memWbSel), .memLink(memLink), .memValid(memValid),
        .dataReadData(dataReadData),
        .wbRd(wbRd), .wbData(wbData), .wbWrite(wbWrite), .retirePulse(retirePulse)
    );

    hazardUnit hazard_i (
        .exRs1(exRs1), .exRs2(exRs2),
        .memRd(memRd), .memRegWrite(memRegWrite),
        .wbRd(wbRd), .wbWrite(wbWrite),
        .idRs1(idInstr.rView.rs1), .idRs2(idInstr.rView.rs2),
        .exRd(exRd), .exMemRead(exMemRead), .branchTaken(branchTaken),
        .stall(stall), .flush(flush), .fwdA(fwdA), .fwdB(fwdB)
    );

    retireCounter retire_i (
        .iCLK(iCLK), .iRST(iRST),
        .retirePulse(retirePulse), .retired(retired)
    );

endmodule

`default_nettype wire

/* execute/executeStage.sv */
`default_nettype none
`include "rv_consts.svh"

module executeStage (
    input  wire                     iCLK,
    input  wire                     iRST,
    input  wire  [`XLEN-1:0]        exPc,
    input  wire  [`XLEN-1:0]        exRs1Val,
    input  wire  [`XLEN-1:0]        exRs2Val,
    input  wire  [`XLEN-1:0]        exImm,
    input  rvPkg::aluOp             exAluOp,
    input  wire                     exUseImm,
    input  wire  [`REG_ADDR_W-1:0]  exRd,
    input  wire                     exMemRead,
    input  wire                     exMemWrite,
    input  wire                     exRegWrite,
    input  wire                     exBranch,
    input  wire                     exBranchNe,
    input  wire                     exJump,
    input  rvPkg::wbSel             exWbSel,
    input  wire                     exValid,
    input  rvPkg::fwdSel            fwdA,
    input  rvPkg::fwdSel            fwdB,
    input  wire  [`XLEN-1:0]        memAluResult,
    input  wire  [`XLEN-1:0]        wbData,
    output logic                    branchTaken,
    output logic [`XLEN-1:0]        branchTarget,
    output logic [`XLEN-1:0]        memAddr,
    output logic [`XLEN-1:0]        memStoreData,
    output logic [`REG_ADDR_W-1:0]  memRd,
    output logic                    memRegWrite,
    output logic                    memRead,
    output logic                    memWrite,
    output rvPkg::wbSel             memWbSel,
    output logic [`XLEN-1:0]        memLink,
    output logic                    memValid
);
    import rvPkg::*;

    logic [`XLEN-1:0] opA, fwdBVal, opB, aluResult;
    logic equal;

    function automatic logic [`XLEN-1:0] pickOperand(input fwdSel sel,
                                                     input logic [`XLEN-1:0] regVal);
        case (sel)
            FWD_MEM: return memAluResult;
            FWD_WB:  return wbData;
            default: return regVal;
        endcase
    endfunction

    always_comb opA     = pickOperand(fwdA, exRs1Val);
    always_comb fwdBVal = pickOperand(fwdB, exRs2Val);  // Also the store data
    assign opB = exUseImm ? exImm : fwdBVal;

    // *********************************************************************
    // ALU
    always_comb begin
        case (exAluOp)
            ALU_SUB: aluResult = opA - opB;
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            ALU_XOR: aluResult = opA ^ opB;
            ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    // Branch resolve where bubbles carry no branch or jump bit
    assign equal        = (opA == fwdBVal);
    assign branchTaken  = exJump | (exBranch & (equal ^ exBranchNe));
    assign branchTarget = exPc + exImm;

    // *********************************************************************
    // EX/MEM register
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            memRegWrite <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            memValid    <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
            memValid    <= exValid;
        end
    end

    always_ff @(posedge iCLK) begin
        memAddr      <= aluResult;
        memStoreData <= fwdBVal;
        memRd        <= exRd;
        memWbSel     <= exWbSel;
        memLink      <= exPc + `XLEN'd4;    // JAL return address
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/rvPkg.sv
design/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
design/memWbStage.sv
design/hazardUnit.sv
design/retireCounter.sv
design/rvCore.sv
bench/rvCore_asserts.sv
bench/rvCoreTb.sv
